// ==== mcu_settings.svh ====
`ifndef MCU_SETTINGS_SVH
`define MCU_SETTINGS_SVH

// Stream and BRAM word width
`define MCU_DATA_WIDTH 16

// BRAM address width, 64 words by default
`define MCU_ADDR_WIDTH 6

// Iteration counter widths
`define MCU_INTER_WIDTH 8
`define MCU_INTRA_WIDTH 8

`endif

// ==== mcu_pkg.sv ====
`include "mcu_settings.svh"

package mcu_pkg;

  // Global controller states, broadcast to the local reader
  typedef enum logic [2:0] {
    glo_idle,
    glo_start,
    glo_run,
    glo_end,
    glo_err
  } glo_state_t;

  // Job descriptor
  // addr_max has one extra bit so a sweep of the whole memory fits
  typedef struct packed {
    logic [`MCU_ADDR_WIDTH:0]    addr_max;
    logic [`MCU_INTER_WIDTH-1:0] inter_max;
    logic [`MCU_INTRA_WIDTH-1:0] intra_max;
  } mcu_job_t;

  // One stream beat
  typedef struct packed {
    logic [`MCU_DATA_WIDTH-1:0] data;
    logic                       last;
  } mcu_beat_t;

endpackage

// ==== mcu_global_fsm.sv ====
`timescale 1ns/100ps

module mcu_global_fsm import mcu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       job_valid,
  input  mcu_job_t   job,
  output logic       job_ready,
  output mcu_job_t   cur_job,
  output glo_state_t glo_state,
  input  logic       done,
  input  logic       fault,
  output logic       busy,
  output logic       job_done,
  output logic       error
);

  glo_state_t state_next;
  logic       accept;

  assign accept = job_valid && job_ready;

  always_comb begin
    state_next = glo_state;
    case (glo_state)
      glo_idle: begin
        if (accept) begin
          state_next = glo_start;
        end
      end
      glo_start: begin
        state_next = glo_run;
      end
      glo_run: begin
        // A refused descriptor wins over completion
        if (fault) begin
          state_next = glo_err;
        end else if (done) begin
          state_next = glo_end;
        end
      end
      glo_end, glo_err: begin
        state_next = glo_idle;
      end
      default: begin
        state_next = glo_idle;
      end
    endcase
  end

  // Outputs are registered from the next state so they stay low in reset
  always_ff @(posedge clk) begin
    if (rst) begin
      glo_state <= glo_idle;
      job_ready <= 1'b0;
      busy      <= 1'b0;
      job_done  <= 1'b0;
      error     <= 1'b0;
    end else begin
      glo_state <= state_next;
      job_ready <= (state_next == glo_idle);
      busy      <= (state_next == glo_start) || (state_next == glo_run);
      job_done  <= (state_next == glo_end);
      error     <= (state_next == glo_err);
    end
  end

  // Descriptor held for the local reader
  always_ff @(posedge clk) begin
    if (accept) begin
      cur_job <= job;
    end
  end

endmodule

// ==== mcu_local_bram_fsm.sv ====
`timescale 1ns/100ps
`include "mcu_settings.svh"

module mcu_local_bram_fsm import mcu_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  glo_state_t                 glo_state,
  input  mcu_job_t                   job,
  output logic                       rd_en,
  output logic [`MCU_ADDR_WIDTH-1:0] rd_addr,
  input  logic [`MCU_DATA_WIDTH-1:0] rd_data,
  input  logic                       rd_ack,
  output mcu_beat_t                  in_beat,
  output logic                       in_valid,
  input  logic                       in_ready,
  input  mcu_beat_t                  head_beat,
  input  logic                       out_valid,
  input  logic                       out_ready,
  output mcu_beat_t                  out_beat,
  output logic                       pop,
  output logic                       done,
  output logic                       fault
);

  localparam logic [1:0] loc_check   = 2'd0;
  localparam logic [1:0] loc_operate = 2'd1;
  localparam logic [1:0] loc_end     = 2'd2;

  logic [1:0]                  loc_state;
  logic [`MCU_ADDR_WIDTH-1:0]  addr_cnt;
  logic [`MCU_INTER_WIDTH-1:0] inter_cnt;
  logic [`MCU_INTRA_WIDTH-1:0] intra_cnt;
  // Words requested from the BRAM and not yet popped from the buffer
  logic [1:0]                  slots;
  logic                        last_q;
  logic                        last_addr;
  logic                        last_inter;
  logic                        bad_job;
  logic                        xfer;
  logic                        final_rep;

  assign bad_job    = (job.addr_max == '0) || (job.inter_max == '0) || (job.intra_max == '0);
  assign last_addr  = ({1'b0, addr_cnt} == job.addr_max - 1'b1);
  assign last_inter = (inter_cnt == job.inter_max - 1'b1);

  // Two slots in total, a pop this cycle frees one
  assign rd_en   = (loc_state == loc_operate) && ((slots != 2'd2) || pop) && in_ready;
  assign rd_addr = addr_cnt;

  // Read data goes straight into the buffer
  assign in_beat  = '{data: rd_data, last: last_q};
  assign in_valid = rd_ack;

  // Repeat counting on the output side
  assign xfer      = out_valid && out_ready;
  assign final_rep = (intra_cnt == job.intra_max - 1'b1);
  assign pop       = xfer && final_rep;
  assign done      = pop && head_beat.last;

  // last only on the final repeat of the tagged word
  assign out_beat = '{data: head_beat.data, last: head_beat.last && final_rep};

  always_ff @(posedge clk) begin
    if (rst) begin
      loc_state <= loc_check;
      addr_cnt  <= '0;
      inter_cnt <= '0;
      intra_cnt <= '0;
      slots     <= '0;
      last_q    <= 1'b0;
      fault     <= 1'b0;
    end else begin
      fault  <= 1'b0;
      last_q <= rd_en && last_addr && last_inter;
      slots  <= slots + {1'b0, rd_en} - {1'b0, pop};

      if (xfer) begin
        intra_cnt <= final_rep ? '0 : intra_cnt + 1'b1;
      end

      case (loc_state)
        loc_check: begin
          addr_cnt  <= '0;
          inter_cnt <= '0;
          if (glo_state == glo_start) begin
            if (bad_job) begin
              fault <= 1'b1;
            end else begin
              loc_state <= loc_operate;
            end
          end
        end
        loc_operate: begin
          if (rd_en) begin
            if (last_addr) begin
              addr_cnt <= '0;
              // Final read of the job issued, wait for it to drain
              if (last_inter) begin
                loc_state <= loc_end;
              end else begin
                inter_cnt <= inter_cnt + 1'b1;
              end
            end else begin
              addr_cnt <= addr_cnt + 1'b1;
            end
          end
        end
        loc_end: begin
          if (done) begin
            loc_state <= loc_check;
          end
        end
        default: begin
          loc_state <= loc_check;
        end
      endcase
    end
  end

endmodule

// ==== axis_skid_buffer.sv ====
`timescale 1ns/100ps

module axis_skid_buffer import mcu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  mcu_beat_t s_beat,
  input  logic      s_valid,
  output logic      s_ready,
  output mcu_beat_t m_beat,
  output logic      m_valid,
  input  logic      m_pop
);

  logic [1:0] count;
  mcu_beat_t  head_q;
  mcu_beat_t  tail_q;
  logic       push;
  logic       pop;
  // Slot the incoming beat lands in after this cycle's pop
  logic [1:0] wr_slot;

  // Empty buffer passes the input straight through
  assign m_valid = (count != 2'd0) || s_valid;
  assign m_beat  = (count == 2'd0) ? s_beat : head_q;
  assign s_ready = (count != 2'd2) || m_pop;

  assign push    = s_valid && s_ready;
  assign pop     = m_pop && m_valid;
  assign wr_slot = count - {1'b0, pop};

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      count <= count + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      head_q <= tail_q;
    end
    if (push && (wr_slot == 2'd0)) begin
      head_q <= s_beat;
    end
    if (push && (wr_slot == 2'd1)) begin
      tail_q <= s_beat;
    end
  end

endmodule

// ==== data_bram.sv ====
`timescale 1ns/100ps
`include "mcu_settings.svh"

module data_bram (
  input  logic                       clk,
  input  logic                       wr_en,
  input  logic [`MCU_ADDR_WIDTH-1:0] wr_addr,
  input  logic [`MCU_DATA_WIDTH-1:0] wr_data,
  input  logic                       rd_en,
  input  logic [`MCU_ADDR_WIDTH-1:0] rd_addr,
  output logic [`MCU_DATA_WIDTH-1:0] rd_data,
  output logic                       rd_ack
);

  localparam int mem_depth = 1 << `MCU_ADDR_WIDTH;

  logic [`MCU_DATA_WIDTH-1:0] mem [mem_depth];

  // Load port, used from outside only
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read, ack follows rd_en by one cycle
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
    rd_ack <= rd_en;
  end

endmodule

// ==== mcu_stream_top.sv ====
`timescale 1ns/100ps
`include "mcu_settings.svh"

module mcu_stream_top import mcu_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       wr_en,
  input  logic [`MCU_ADDR_WIDTH-1:0] wr_addr,
  input  logic [`MCU_DATA_WIDTH-1:0] wr_data,
  input  logic                       job_valid,
  input  mcu_job_t                   job,
  output logic                       job_ready,
  output mcu_beat_t                  out_beat,
  output logic                       out_valid,
  input  logic                       out_ready,
  output logic                       busy,
  output logic                       job_done,
  output logic                       error
);

  mcu_job_t                   cur_job;
  glo_state_t                 glo_state;
  logic                       done;
  logic                       fault;
  logic                       rd_en;
  logic [`MCU_ADDR_WIDTH-1:0] rd_addr;
  logic [`MCU_DATA_WIDTH-1:0] rd_data;
  logic                       rd_ack;
  mcu_beat_t                  push_beat;
  logic                       push_valid;
  logic                       push_ready;
  mcu_beat_t                  head_beat;
  logic                       pop;

  mcu_global_fsm mcu_global_fsm_i (
    .clk       (clk),
    .rst       (rst),
    .job_valid (job_valid),
    .job       (job),
    .job_ready (job_ready),
    .cur_job   (cur_job),
    .glo_state (glo_state),
    .done      (done),
    .fault     (fault),
    .busy      (busy),
    .job_done  (job_done),
    .error     (error)
  );

  mcu_local_bram_fsm mcu_local_bram_fsm_i (
    .clk       (clk),
    .rst       (rst),
    .glo_state (glo_state),
    .job       (cur_job),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .rd_ack    (rd_ack),
    .in_beat   (push_beat),
    .in_valid  (push_valid),
    .in_ready  (push_ready),
    .head_beat (head_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat),
    .pop       (pop),
    .done      (done),
    .fault     (fault)
  );

  // Head word stays put until the reader pops it
  axis_skid_buffer axis_skid_buffer_i (
    .clk     (clk),
    .rst     (rst),
    .s_beat  (push_beat),
    .s_valid (push_valid),
    .s_ready (push_ready),
    .m_beat  (head_beat),
    .m_valid (out_valid),
    .m_pop   (pop)
  );

  data_bram data_bram_i (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .rd_ack  (rd_ack)
  );

endmodule

// ==== mcu_stream_assertions.sv ====
`timescale 1ns/100ps

module mcu_stream_assertions import mcu_pkg::*; (
  input logic      clk,
  input logic      rst,
  input logic      job_valid,
  input logic      job_ready,
  input mcu_beat_t out_beat,
  input logic      out_valid,
  input logic      out_ready,
  input logic      busy,
  input logic      job_done,
  input logic      error
);

  int fail_count = 0;

  task automatic record_failure(input string what);
    fail_count++;
    $error("%s", what);
  endtask

  // A stalled beat keeps its payload
  assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else record_failure("out_beat changed or out_valid dropped while stalled");

  // Idle outputs at reset release and job_ready one cycle later
  assert property (@(posedge clk)
    $fell(rst) |-> (!out_valid && !busy && !job_done && !error && !job_ready) ##1 job_ready)
    else record_failure("outputs wrong around reset release");

  // Busy from acceptance until the job ends
  assert property (@(posedge clk) disable iff (rst)
    job_valid && job_ready |=> busy)
    else record_failure("busy not raised after a job was accepted");

  assert property (@(posedge clk) disable iff (rst)
    busy |=> busy || job_done || error)
    else record_failure("busy dropped before the job ended");

  // Final beat closes the job
  assert property (@(posedge clk) disable iff (rst)
    out_valid && out_ready && out_beat.last |=> job_done && !busy)
    else record_failure("no job_done or busy still high after the last beat");

  // Single-cycle status pulses
  assert property (@(posedge clk) disable iff (rst)
    job_done || error |=> !job_done && !error)
    else record_failure("job_done or error held longer than one cycle");

endmodule

bind mcu_stream_top mcu_stream_assertions mcu_stream_assertions_i (.*);

// ==== tb_mcu_stream.sv ====
`timescale 1ns/100ps
`include "mcu_settings.svh"

module tb_mcu_stream import mcu_pkg::*; ();

  logic                       clk;
  logic                       rst;
  logic                       wr_en;
  logic [`MCU_ADDR_WIDTH-1:0] wr_addr;
  logic [`MCU_DATA_WIDTH-1:0] wr_data;
  logic                       job_valid;
  mcu_job_t                   job;
  logic                       job_ready;
  mcu_beat_t                  out_beat;
  logic                       out_valid;
  logic                       out_ready;
  logic                       busy;
  logic                       job_done;
  logic                       error;

  // Copy of what was loaded into the BRAM
  logic [`MCU_DATA_WIDTH-1:0] mem_model [1 << `MCU_ADDR_WIDTH];
  mcu_beat_t                  expect_q [$];
  int                         errors = 0;

  mcu_stream_top mcu_stream_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Scoreboard on every output transfer
  always @(posedge clk) begin
    if (!rst && out_valid && out_ready) begin
      if (expect_q.size() == 0) begin
        errors++;
        $display("Output beat at %0t arrived with no beat expected", $time);
      end else begin
        assert (out_beat == expect_q[0]) else begin
          errors++;
          $display("ERROR %0t out_beat expected %h got %h", $time, expect_q[0], out_beat);
        end
        void'(expect_q.pop_front());
      end
    end
  end

  task automatic wait_job_ready();
    int n = 0;
    while (!job_ready && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (!job_ready) begin
      errors++;
      $display("Timed out waiting for job_ready at %0t", $time);
    end
  endtask

  task automatic run_job(input int addr_max, input int inter_max, input int intra_max);
    int n = 0;
    bit bad;
    bad = (addr_max == 0) || (inter_max == 0) || (intra_max == 0);
    // Repeats innermost, then addresses, then sweeps; a zero count predicts nothing
    for (int i = 0; i < inter_max; i++) begin
      for (int a = 0; a < addr_max; a++) begin
        for (int r = 0; r < intra_max; r++) begin
          expect_q.push_back('{data: mem_model[a[`MCU_ADDR_WIDTH-1:0]],
            last: (i == inter_max - 1) && (a == addr_max - 1) && (r == intra_max - 1)});
        end
      end
    end
    wait_job_ready();
    job_valid     = 1'b1;
    job.addr_max  = addr_max[`MCU_ADDR_WIDTH:0];
    job.inter_max = inter_max[`MCU_INTER_WIDTH-1:0];
    job.intra_max = intra_max[`MCU_INTRA_WIDTH-1:0];
    @(negedge clk);
    job_valid = 1'b0;
    // Refused job has to flag its error within 4 cycles
    while (!job_done && !error && n < (bad ? 4 : 20000)) begin
      @(negedge clk);
      n++;
    end
    if (bad && !error) begin
      errors++;
      $display("Refused job gave no error pulse at %0t", $time);
    end
    if (!bad && !job_done) begin
      errors++;
      $display("Timed out waiting for job_done at %0t", $time);
    end
    if (expect_q.size() != 0) begin
      errors++;
      $display("%0d predicted beats were never sent", expect_q.size());
      expect_q.delete();
    end
    wait_job_ready();
  endtask

  initial begin
    int rnd;
    int failed_asserts;
    void'($urandom(90117));
    rst       = 1'b1;
    wr_en     = 1'b0;
    wr_addr   = '0;
    wr_data   = '0;
    job_valid = 1'b0;
    job       = '0;
    out_ready = 1'b0;
    // Random back-pressure for the whole run
    fork
      forever begin
        @(negedge clk);
        out_ready = 1'($urandom_range(0, 1));
      end
    join_none
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int a = 0; a < (1 << `MCU_ADDR_WIDTH); a++) begin
      rnd     = $urandom;
      wr_en   = 1'b1;
      wr_addr = a[`MCU_ADDR_WIDTH-1:0];
      wr_data = rnd[`MCU_DATA_WIDTH-1:0];
      mem_model[wr_addr] = wr_data;
      @(negedge clk);
    end
    wr_en = 1'b0;
    repeat (6) begin
      run_job($urandom_range(1, 8), $urandom_range(1, 3), $urandom_range(1, 3));
    end
    // One zero count in each field
    run_job(0, 2, 2);
    run_job(3, 0, 2);
    run_job(3, 2, 0);
    // Whole memory, swept twice, each word sent twice
    run_job(1 << `MCU_ADDR_WIDTH, 2, 2);
    failed_asserts = mcu_stream_top_i.mcu_stream_assertions_i.fail_count;
    $display("Run complete with %0d scoreboard errors and %0d assertion failures",
             errors, failed_asserts);
    if (errors == 0 && failed_asserts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+.
mcu_pkg.sv
mcu_global_fsm.sv
mcu_local_bram_fsm.sv
axis_skid_buffer.sv
data_bram.sv
mcu_stream_top.sv
mcu_stream_assertions.sv
tb_mcu_stream.sv
